// ==== gf128_lane.sv ====
`timescale 1ns/1ps

module gf128_lane import ghash_pkg::*; #(
    parameter int LANE = 0                              // Block index served
) (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    ghash_feed_if.lane                  i_feed,
    output logic [NB_BLOCK-1:0]         o_product
);

    logic [NB_BLOCK-1:0]                blk;
    logic [NB_BLOCK-1:0]                pwr;

    assign blk = i_feed.blocks[LANE];
    assign pwr = i_feed.powers[LANE];                   // Zero for a skipped block

    ////////////////////////////////////////
    // Product register
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_product <= '0;
        end else if (i_feed.valid) begin
            o_product <= gf128_mul(blk, pwr);           // Held between beats
        end
    end

endmodule

// ==== ghash.f ====
ghash_pkg.sv
ghash_feed_if.sv
ghash_feeder.sv
gf128_lane.sv
ghash_accumulator.sv
ghash_top.sv
tb_ghash.sv

// ==== ghash_accumulator.sv ====
`timescale 1ns/1ps

module ghash_accumulator import ghash_pkg::*; (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    ghash_feed_if.mon                   i_feed,
    input  logic [N_BLOCKS-1:0][NB_BLOCK-1:0] i_products,
    input  logic [NB_DATA-1:0]          i_h_powers,
    output logic [NB_BLOCK-1:0]         o_tag,
    output logic                        o_done
);

    acc_state_e                         state;
    logic                               feed_sop;
    logic                               feed_last;
    logic                               v_d;            // Aligned with lane products
    logic                               sop_d;
    logic                               last_d;
    logic [NB_COUNT-1:0]                count_d;
    logic                               take;
    logic [NB_BLOCK-1:0]                hash;
    logic [NB_BLOCK-1:0]                h_sel;
    logic [NB_BLOCK-1:0]                prod_xor;
    logic [NB_BLOCK-1:0]                new_hash;

    assign feed_sop  = (i_feed.kind == BEAT_FIRST) || (i_feed.kind == BEAT_ONLY);
    assign feed_last = i_feed.valid &&
                       ((i_feed.kind == BEAT_LAST) || (i_feed.kind == BEAT_ONLY));

    always_ff @(posedge i_clock) begin
        sop_d   <= feed_sop;
        last_d  <= feed_last;
        count_d <= i_feed.count;
    end

    ////////////////////////////////////////
    // Hash update
    ////////////////////////////////////////
    always_comb begin
        h_sel = '0;
        for (int i = 0; i < N_BLOCKS; i++) begin
            if (count_d == NB_COUNT'(i + 1)) begin
                h_sel = i_h_powers[i*NB_BLOCK +: NB_BLOCK];     // H^count_d
            end
        end
    end

    always_comb begin
        prod_xor = '0;
        for (int j = 0; j < N_BLOCKS; j++) begin
            prod_xor = prod_xor ^ i_products[j];
        end
    end

    // A sop beat starts from zero even in the middle of a message
    assign take     = v_d && (sop_d || (state == ACC_RUN));
    assign new_hash = gf128_mul(sop_d ? '0 : hash, h_sel) ^ prod_xor;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state  <= ACC_IDLE;
            v_d    <= 1'b0;
            o_done <= 1'b0;
        end else begin
            v_d    <= i_feed.valid;
            o_done <= take && last_d;                   // One-cycle pulse
            if (take) begin
                state <= last_d ? ACC_IDLE : ACC_RUN;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (take) begin
            hash <= new_hash;
        end
        if (take && last_d) begin
            o_tag <= new_hash;                          // Held until next tag
        end
    end

    // Every accepted beat outside a message must open one
    a_no_orphan: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (v_d && (state == ACC_IDLE)) |-> sop_d);

    // A beat with no blocks would select a zero key power and wipe the hash
    a_count_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        v_d |-> ((count_d != '0) && (count_d <= NB_COUNT'(N_BLOCKS))));

endmodule

// ==== ghash_feed_if.sv ====
`timescale 1ns/1ps

interface ghash_feed_if import ghash_pkg::*; ();

    logic                               valid;          // One distributed beat
    beat_kind_e                         kind;           // Position in message
    logic [NB_COUNT-1:0]                count;          // Valid blocks, 1..N_BLOCKS
    logic [N_BLOCKS-1:0][NB_BLOCK-1:0]  blocks;         // Skipped blocks are zero
    logic [N_BLOCKS-1:0][NB_BLOCK-1:0]  powers;         // Key power per lane

    // Feeder side
    modport src (
        output valid,
        output kind,
        output count,
        output blocks,
        output powers
    );

    // Each lane reads its own element
    modport lane (
        input  valid,
        input  blocks,
        input  powers
    );

    // Accumulator only needs the control fields
    modport mon (
        input  valid,
        input  kind,
        input  count
    );

endinterface

// ==== ghash_feeder.sv ====
`timescale 1ns/1ps

module ghash_feeder import ghash_pkg::*; (
    input  logic                        i_clock,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  logic                        i_sop,
    input  logic                        i_eop,
    input  logic [N_BLOCKS-1:0]         i_skip,
    input  logic [NB_DATA-1:0]          i_data,
    input  logic [NB_DATA-1:0]          i_h_powers,
    ghash_feed_if.src                   o_feed
);

    logic [N_BLOCKS-1:0]                keep;           // Unskipped blocks
    logic [NB_COUNT-1:0]                n_valid;
    beat_kind_e                         kind;
    logic [N_BLOCKS-1:0][NB_BLOCK-1:0]  blk_d;
    logic [N_BLOCKS-1:0][NB_BLOCK-1:0]  pow_d;

    assign keep = ~i_skip;

    ////////////////////////////////////////
    // Beat decode
    ////////////////////////////////////////
    always_comb begin
        n_valid = '0;
        for (int j = 0; j < N_BLOCKS; j++) begin
            if (keep[j] && (n_valid == NB_COUNT'(j))) begin
                n_valid = n_valid + 1'b1;               // Still inside leading run
            end
        end
    end

    always_comb begin
        case ({i_sop, i_eop})
            2'b11:   kind = BEAT_ONLY;
            2'b10:   kind = BEAT_FIRST;
            2'b01:   kind = BEAT_LAST;
            default: kind = BEAT_MID;
        endcase
    end

    // Block j is weighted by H^(n_valid-j), stored at power index n_valid-j-1
    always_comb begin
        for (int j = 0; j < N_BLOCKS; j++) begin
            blk_d[j] = (NB_COUNT'(j) < n_valid) ? i_data[j*NB_BLOCK +: NB_BLOCK] : '0;
            pow_d[j] = '0;
            for (int i = 0; i < N_BLOCKS; i++) begin
                if (NB_COUNT'(i + j + 1) == n_valid) begin
                    pow_d[j] = i_h_powers[i*NB_BLOCK +: NB_BLOCK];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            o_feed.valid <= 1'b0;
        end else begin
            o_feed.valid <= i_valid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_feed.kind   <= kind;
            o_feed.count  <= n_valid;
            o_feed.blocks <= blk_d;
            o_feed.powers <= pow_d;
        end
    end

    // Unskipped blocks must be a contiguous run starting at block 0
    a_skip_trailing: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_valid |-> (keep[0] && ((keep & (keep + 1'b1)) == '0)));

endmodule

// ==== ghash_pkg.sv ====
package ghash_pkg;

    ////////////////////////////////////////
    // Block and lane geometry
    ////////////////////////////////////////
    localparam int NB_BLOCK = 128;                      // Bits per GHASH block
    localparam int N_BLOCKS = 4;                        // Blocks per beat, one lane each
    localparam int NB_DATA  = N_BLOCKS * NB_BLOCK;      // Width of a full beat
    localparam int NB_COUNT = $clog2(N_BLOCKS + 1);     // Holds 0..N_BLOCKS

    // Reduction constant for x^128 + x^7 + x^2 + x + 1 in reflected order
    localparam logic [NB_BLOCK-1:0] GF_R = {8'he1, 120'h0};

    ////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        BEAT_FIRST = 2'd0,                              // sop only
        BEAT_MID   = 2'd1,
        BEAT_LAST  = 2'd2,                              // eop only
        BEAT_ONLY  = 2'd3                               // One-beat message
    } beat_kind_e;

    typedef enum logic {
        ACC_IDLE = 1'b0,                                // Waiting for a sop beat
        ACC_RUN  = 1'b1
    } acc_state_e;

    ////////////////////////////////////////
    // GF(2^128) multiply, GCM bit order
    ////////////////////////////////////////
    // Bit 127 is the x^0 coefficient, so the scan runs from the MSB down
    function automatic logic [NB_BLOCK-1:0] gf128_mul(
        input logic [NB_BLOCK-1:0] a,
        input logic [NB_BLOCK-1:0] b
    );
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        z = '0;
        v = b;
        for (int i = NB_BLOCK - 1; i >= 0; i--) begin
            if (a[i]) begin
                z = z ^ v;                              // Accumulate shifted operand
            end
            v = v[0] ? ((v >> 1) ^ GF_R) : (v >> 1);    // Multiply by x, reduce
        end
        return z;
    endfunction

endpackage

// ==== ghash_top.sv ====
`timescale 1ns/1ps

module ghash_top import ghash_pkg::*; (
    // Outputs
    output logic [NB_BLOCK-1:0]         o_tag,
    output logic                        o_done,
    // Inputs
    input  logic [NB_DATA-1:0]          i_data,
    input  logic [NB_DATA-1:0]          i_h_powers,         // Entry i holds H^(i+1)
    input  logic [N_BLOCKS-1:0]         i_skip,
    input  logic                        i_sop,
    input  logic                        i_eop,
    input  logic                        i_valid,
    input  logic                        i_rst_n,
    input  logic                        i_clock
);

    logic [N_BLOCKS-1:0][NB_BLOCK-1:0]  lane_products;

    ghash_feed_if feed_if ();

    ////////////////////////////////////////
    // Beat distribution
    ////////////////////////////////////////
    ghash_feeder u_ghash_feeder (
        .i_clock        ( i_clock       ),
        .i_rst_n        ( i_rst_n       ),
        .i_valid        ( i_valid       ),
        .i_sop          ( i_sop         ),
        .i_eop          ( i_eop         ),
        .i_skip         ( i_skip        ),
        .i_data         ( i_data        ),
        .i_h_powers     ( i_h_powers    ),
        .o_feed         ( feed_if.src   )
    );

    // One multiplier lane per block of the beat
    for (genvar g = 0; g < N_BLOCKS; g++) begin : g_lane
        gf128_lane #(
            .LANE       ( g                 )
        ) u_gf128_lane (
            .i_clock    ( i_clock           ),
            .i_rst_n    ( i_rst_n           ),
            .i_feed     ( feed_if.lane      ),
            .o_product  ( lane_products[g]  )
        );
    end

    ////////////////////////////////////////
    // Running hash
    ////////////////////////////////////////
    ghash_accumulator u_ghash_accumulator (
        .i_clock        ( i_clock       ),
        .i_rst_n        ( i_rst_n       ),
        .i_feed         ( feed_if.mon   ),
        .i_products     ( lane_products ),
        .i_h_powers     ( i_h_powers    ),
        .o_tag          ( o_tag         ),
        .o_done         ( o_done        )
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the GHASH testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ghash -f ghash.f -o sim_ghash

output=$(./obj_dir/sim_ghash)
echo "$output"

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

// ==== tb_ghash.sv ====
`timescale 1ns/1ps

module tb_ghash import ghash_pkg::*; ;

    localparam int          CLK_PERIOD   = 10;
    localparam int unsigned SEED         = 32'hf21b_e59b;
    localparam int          N_ONE        = 20;          // One-beat messages
    localparam int          N_MULTI      = 12;          // 2..8 beats each
    localparam int          N_STREAM     = 16;          // 1..4 beats each
    localparam int          N_RESTART    = 6;           // Up to 7 beats each
    localparam int          MAX_BEATS    = N_ONE + N_MULTI * 8 + N_STREAM * 4 + N_RESTART * 7;
    localparam int          WATCHDOG_CYC = MAX_BEATS * 20 + 500;
    localparam int          DRAIN_CYCLES = 10;

    logic                   clock;
    logic                   rst_n;
    logic                   valid;
    logic                   sop;
    logic                   eop;
    logic [N_BLOCKS-1:0]    skip;
    logic [NB_DATA-1:0]     data;
    logic [NB_DATA-1:0]     h_powers;
    logic [NB_BLOCK-1:0]    tag;
    logic                   done;

    logic [NB_BLOCK-1:0]    h_key;
    logic [NB_BLOCK-1:0]    model_hash;                 // Horner state of the model
    logic [NB_BLOCK-1:0]    exp_tags[$];
    int unsigned            exp_cycles[$];
    int unsigned            cycle;
    int                     errors;
    int                     test_start_errors;
    int                     tests_run;
    int                     tests_failed;

    ghash_top ghash_top_inst (
        .o_tag      ( tag       ),
        .o_done     ( done      ),
        .i_data     ( data      ),
        .i_h_powers ( h_powers  ),
        .i_skip     ( skip      ),
        .i_sop      ( sop       ),
        .i_eop      ( eop       ),
        .i_valid    ( valid     ),
        .i_rst_n    ( rst_n     ),
        .i_clock    ( clock     )
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    // GCM field product, x^0 in the MSB, reduced by x^128 + x^7 + x^2 + x + 1
    function automatic logic [NB_BLOCK-1:0] field_mul(
        input logic [NB_BLOCK-1:0] x,
        input logic [NB_BLOCK-1:0] y
    );
        logic [NB_BLOCK-1:0] z;
        logic [NB_BLOCK-1:0] v;
        z = '0;
        v = y;
        for (int i = 0; i < NB_BLOCK; i++) begin
            if (x[NB_BLOCK-1-i]) begin
                z = z ^ v;
            end
            if (v[0]) begin
                v = (v >> 1) ^ {8'b1110_0001, 120'd0};
            end else begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

    function automatic logic [NB_BLOCK-1:0] rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic logic [NB_DATA-1:0] rand_beat();
        logic [NB_DATA-1:0] b;
        for (int j = 0; j < N_BLOCKS; j++) begin
            b[j*NB_BLOCK +: NB_BLOCK] = rand_block();
        end
        return b;
    endfunction

    // Trailing run of skipped blocks after the first n_valid
    function automatic logic [N_BLOCKS-1:0] skip_mask(input int n_valid);
        logic [N_BLOCKS-1:0] m;
        m = '0;
        for (int j = 0; j < N_BLOCKS; j++) begin
            if (j >= n_valid) begin
                m[j] = 1'b1;
            end
        end
        return m;
    endfunction

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////
    task automatic send_beat(input logic first, input logic last, input int n_valid,
                             input logic [NB_DATA-1:0] beat);
        @(posedge clock);
        #1;
        valid = 1'b1;
        sop   = first;
        eop   = last;
        skip  = skip_mask(n_valid);
        data  = beat;                                   // Skipped blocks carry noise
        if (first) begin
            model_hash = '0;
        end
        for (int j = 0; j < n_valid; j++) begin
            model_hash = field_mul(model_hash ^ beat[j*NB_BLOCK +: NB_BLOCK], h_key);
        end
        if (last) begin
            exp_tags.push_back(model_hash);
            exp_cycles.push_back(cycle + 3);            // Done in the third cycle after
        end
    endtask

    task automatic go_idle();
        @(posedge clock);
        #1;
        valid = 1'b0;
        sop   = 1'b0;
        eop   = 1'b0;
        skip  = '0;
    endtask

    task automatic drain_tags();
        int waited;
        waited = 0;
        while ((exp_tags.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(posedge clock);
            waited++;
        end
        assert (exp_tags.size() == 0) else begin
            $display("Missing tags at %0t: %0d expected o_done pulses never came",
                     $time, exp_tags.size());
            errors++;
            exp_tags.delete();
            exp_cycles.delete();
        end
        repeat (3) @(posedge clock);                    // Catch stray pulses
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////
    // Output checker
    ////////////////////////////////////////
    always @(negedge clock) begin
        logic [NB_BLOCK-1:0] want_tag;
        int unsigned         want_cycle;
        if (rst_n && done) begin
            assert (exp_tags.size() != 0) else begin
                $display("Unexpected o_done at %0t with no message outstanding", $time);
                errors++;
            end
            if (exp_tags.size() != 0) begin
                want_tag   = exp_tags.pop_front();
                want_cycle = exp_cycles.pop_front();
                assert (tag === want_tag) else begin
                    $display("Error at %0t: o_tag expected %h, got %h", $time, want_tag, tag);
                    errors++;
                end
                assert (cycle == want_cycle) else begin
                    $display("Error at %0t: o_done cycle expected %0d, got %0d",
                             $time, want_cycle, cycle);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        logic [NB_BLOCK-1:0] pw;
        int                  n_beats;
        int                  n_keep;
        int                  gap;
        void'($urandom(SEED));
        clock = 1'b0;
        rst_n = 1'b0;
        valid = 1'b0;
        sop   = 1'b0;
        eop   = 1'b0;
        skip  = '0;
        data  = '0;
        cycle = 0;
        errors = 0;
        test_start_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        model_hash = '0;
        h_key = rand_block();
        pw = h_key;
        for (int i = 0; i < N_BLOCKS; i++) begin
            h_powers[i*NB_BLOCK +: NB_BLOCK] = pw;     // Entry i is H^(i+1)
            pw = field_mul(pw, h_key);
        end
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;

        repeat (20) begin
            @(negedge clock);
            assert (done === 1'b0) else begin
                $display("Error at %0t: o_done expected 0, got %b", $time, done);
                errors++;
            end
        end
        end_test("idle after reset");

        for (int m = 0; m < N_ONE; m++) begin
            send_beat(1'b1, 1'b1, N_BLOCKS, rand_beat());
            go_idle();
            drain_tags();
        end
        end_test("one-beat messages");

        for (int m = 0; m < N_MULTI; m++) begin
            n_beats = 2 + int'($urandom_range(6));
            send_beat(1'b1, 1'b0, N_BLOCKS, rand_beat());
            for (int b = 1; b < n_beats - 1; b++) begin
                send_beat(1'b0, 1'b0, N_BLOCKS, rand_beat());
            end
            n_keep = 1 + int'($urandom_range(N_BLOCKS - 1));
            send_beat(1'b0, 1'b1, n_keep, rand_beat());
            go_idle();
            drain_tags();
        end
        end_test("multi-beat messages");

        // First half back to back, second half with idle gaps
        for (int m = 0; m < N_STREAM; m++) begin
            n_beats = 1 + int'($urandom_range(3));
            for (int b = 0; b < n_beats; b++) begin
                gap = (m >= N_STREAM / 2) ? int'($urandom_range(3)) : 0;
                repeat (gap) go_idle();
                n_keep = (b == n_beats - 1) ? 1 + int'($urandom_range(N_BLOCKS - 1)) : N_BLOCKS;
                send_beat(b == 0, b == n_beats - 1, n_keep, rand_beat());
            end
        end
        go_idle();
        drain_tags();
        end_test("streamed messages");

        for (int m = 0; m < N_RESTART; m++) begin
            n_beats = 1 + int'($urandom_range(2));
            for (int b = 0; b < n_beats; b++) begin
                send_beat(b == 0, 1'b0, N_BLOCKS, rand_beat());  // Abandoned message
            end
            n_beats = 1 + int'($urandom_range(3));
            for (int b = 0; b < n_beats; b++) begin
                n_keep = (b == n_beats - 1) ? 1 + int'($urandom_range(N_BLOCKS - 1)) : N_BLOCKS;
                send_beat(b == 0, b == n_beats - 1, n_keep, rand_beat());
            end
            go_idle();
            drain_tags();
        end
        end_test("mid-message restart");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
